// ==== breakout_pixel_top.f ====
+incdir+sim
logic/breakout_pkg.sv
logic/ball_motion.sv
logic/brick_field.sv
logic/bounce_control.sv
logic/pixel_color.sv
logic/breakout_pixel_top.sv
sim/breakout_tb.sv

// ==== sim/breakout_model.svh ====
`ifndef BREAKOUT_MODEL_SVH
`define BREAKOUT_MODEL_SVH

// uses BOARD_W, BOARD_H, BRICK_W, BRICK_H, NB, BALL_SZ and SPEED of the including module

// point inside a w by h rectangle, edges wrap at coordinate width
function automatic logic in_rect(
    input breakout_pkg::coord_t px, py, left, top,
    input int                   w, h
);
    breakout_pkg::coord_t right;
    breakout_pkg::coord_t bottom;
    right  = left + breakout_pkg::coord_t'(w - 1);
    bottom = top + breakout_pkg::coord_t'(h - 1);
    return (px >= left) && (px <= right) && (py >= top) && (py <= bottom);
endfunction

// ball bottom row inside a brick's rows while the columns overlap
function automatic logic ball_on_brick(
    input breakout_pkg::coord_t          bx, by,
    input breakout_pkg::coord_t [NB-1:0] kx, ky
);
    breakout_pkg::coord_t right;
    breakout_pkg::coord_t bottom;
    breakout_pkg::coord_t k_right;
    breakout_pkg::coord_t k_bottom;
    logic                 hit;
    right  = bx + breakout_pkg::coord_t'(BALL_SZ - 1);
    bottom = by + breakout_pkg::coord_t'(BALL_SZ - 1);
    hit    = 1'b0;
    for (int i = 0; i < NB; i++) begin
        k_right  = kx[i] + breakout_pkg::coord_t'(BRICK_W - 1);
        k_bottom = ky[i] + breakout_pkg::coord_t'(BRICK_H - 1);
        if (bottom >= ky[i] && bottom <= k_bottom && right >= kx[i] && bx <= k_right) begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

// colour priority: blanking, board, ball, brick, background
function automatic breakout_pkg::rgb_t expected_rgb(
    input logic                          on,
    input breakout_pkg::coord_t          px, py, bx, by, pad_x, pad_y,
    input breakout_pkg::coord_t [NB-1:0] kx, ky
);
    logic in_brick;
    in_brick = 1'b0;
    for (int i = 0; i < NB; i++) begin
        if (in_rect(px, py, kx[i], ky[i], BRICK_W, BRICK_H)) begin
            in_brick = 1'b1;
        end
    end
    if (!on) return breakout_pkg::BLACK;
    if (in_rect(px, py, pad_x, pad_y, BOARD_W, BOARD_H)) return breakout_pkg::BOARD_RGB;
    if (in_rect(px, py, bx, by, BALL_SZ, BALL_SZ)) return breakout_pkg::BALL_RGB;
    if (in_brick) return breakout_pkg::BRICK_RGB;
    return breakout_pkg::BG_RGB;
endfunction

// one frame: move by the old step, pick the new step from the old position
task automatic step_ball(
    input breakout_pkg::coord_t          pad_x, pad_y,
    input breakout_pkg::coord_t [NB-1:0] kx, ky,
    inout breakout_pkg::coord_t          bx, by,
    inout breakout_pkg::vel_t            vx, vy,
    inout logic                          hit_seen
);
    breakout_pkg::vel_t   nvx;
    breakout_pkg::vel_t   nvy;
    breakout_pkg::coord_t right;
    breakout_pkg::coord_t bottom;
    logic                 pad;
    logic                 brick;
    right  = bx + breakout_pkg::coord_t'(BALL_SZ - 1);
    bottom = by + breakout_pkg::coord_t'(BALL_SZ - 1);
    // board rows run from board_y to board_y + height
    pad    = (bottom >= pad_y) && (bottom <= pad_y + breakout_pkg::coord_t'(BOARD_H)) &&
             (right >= pad_x) && (bx <= pad_x + breakout_pkg::coord_t'(BOARD_W - 1));
    brick  = ball_on_brick(bx, by, kx, ky);
    nvx    = vx;
    nvy    = vy;
    if (by == '0) begin
        nvy = breakout_pkg::vel_t'(SPEED);
    end else if (by > breakout_pkg::Y_MAX) begin
        nvy = breakout_pkg::vel_t'(-SPEED);
    end else if (pad || brick) begin
        nvy = breakout_pkg::vel_t'(-SPEED);
        nvx = -vx;
    end
    // side walls last
    if (bx == '0) begin
        nvx = breakout_pkg::vel_t'(SPEED);
    end else if (right > breakout_pkg::X_MAX) begin
        nvx = breakout_pkg::vel_t'(-SPEED);
    end
    if (brick) hit_seen = 1'b1;
    bx = bx + breakout_pkg::coord_t'(vx);
    by = by + breakout_pkg::coord_t'(vy);
    vx = nvx;
    vy = nvy;
endtask

`endif

// ==== sim/breakout_tb.sv ====
`timescale 1ns/1ps

module breakout_tb;

    localparam int BOARD_W = 64;
    localparam int BOARD_H = 8;
    localparam int BRICK_W = 30;
    localparam int BRICK_H = 30;
    localparam int NB      = 6;
    localparam int BALL_SZ = 8;
    localparam int SPEED   = 2;
    localparam int START_X = 316;
    localparam int START_Y = 392;

    logic                                clk;
    logic                                reset;
    logic                                video_on;
    breakout_pkg::coord_t                x;
    breakout_pkg::coord_t                y;
    breakout_pkg::coord_t                board_x;
    breakout_pkg::coord_t                board_y;
    breakout_pkg::coord_t [NB-1:0]       brick_x;
    breakout_pkg::coord_t [NB-1:0]       brick_y;
    breakout_pkg::rgb_t                  rgb;
    logic                                collision;

    // model of the ball and the collision flag
    breakout_pkg::coord_t m_x;
    breakout_pkg::coord_t m_y;
    breakout_pkg::vel_t   m_vx;
    breakout_pkg::vel_t   m_vy;
    logic                 m_coll;

    // expected values for the compare process
    logic                 check_en;
    breakout_pkg::rgb_t   exp_rgb;
    logic                 exp_coll;

    int   seed;
    int   errors;
    int   checks;
    int   passed;
    int   failed;
    logic timed_out;

    `include "breakout_model.svh"

    breakout_pixel_top #(
        .BOARD_WIDTH  (BOARD_W),
        .BOARD_HEIGHT (BOARD_H),
        .BRICK_WIDTH  (BRICK_W),
        .BRICK_HEIGHT (BRICK_H),
        .NUM_BRICKS   (NB),
        .BALL_SIZE    (BALL_SZ),
        .BALL_SPEED   (SPEED),
        .BALL_START_X (START_X),
        .BALL_START_Y (START_Y)
    ) breakout_pixel_top_i (
        .clk       (clk),
        .reset     (reset),
        .video_on  (video_on),
        .x         (x),
        .y         (y),
        .board_x   (board_x),
        .board_y   (board_y),
        .brick_x   (brick_x),
        .brick_y   (brick_y),
        .rgb       (rgb),
        .collision (collision)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // compare process, inputs settled since the falling edge
    always @(posedge clk) begin
        if (check_en) begin
            checks++;
            if (rgb !== exp_rgb) begin
                errors++;
                $display("error at %0t: rgb %h expected %h at (%0d,%0d)",
                         $time, rgb, exp_rgb, x, y);
            end
            if (collision !== exp_coll) begin
                errors++;
                $display("error at %0t: collision %b expected %b", $time, collision, exp_coll);
            end
        end
    end

    task automatic apply_reset;
        @(negedge clk);
        check_en = 1'b0;
        reset    = 1'b1;
        repeat (5) @(negedge clk);
        reset  = 1'b0;
        m_x    = breakout_pkg::coord_t'(START_X);
        m_y    = breakout_pkg::coord_t'(START_Y);
        m_vx   = breakout_pkg::vel_t'(SPEED);
        m_vy   = breakout_pkg::vel_t'(-SPEED);
        m_coll = 1'b0;
    endtask

    // brick i at (x0 + dx * i, y0)
    task automatic place_bricks(input int x0, input int y0, input int dx);
        for (int i = 0; i < NB; i++) begin
            brick_x[i] = breakout_pkg::coord_t'(x0 + dx * i);
            brick_y[i] = breakout_pkg::coord_t'(y0);
        end
    endtask

    // one pixel, compared on the next rising edge
    task automatic probe(input logic on, input breakout_pkg::coord_t px, py);
        @(negedge clk);
        video_on = on;
        x        = px;
        y        = py;
        exp_rgb  = expected_rgb(on, px, py, m_x, m_y, board_x, board_y, brick_x, brick_y);
        exp_coll = m_coll;
        check_en = 1'b1;
    endtask

    // refresh line, column 0, for a single cycle
    task automatic frame_tick;
        @(negedge clk);
        check_en = 1'b0;
        video_on = 1'b0;
        x        = '0;
        y        = breakout_pkg::REFRESH_LINE;
        step_ball(board_x, board_y, brick_x, brick_y, m_x, m_y, m_vx, m_vy, m_coll);
    endtask

    // predicted corner, then its left and upper neighbours
    task automatic check_ball;
        probe(1'b1, m_x, m_y);
        probe(1'b1, m_x - 1'b1, m_y);
        probe(1'b1, m_x, m_y - 1'b1);
    endtask

    task automatic finish_test(input string name, input int err_before);
        @(negedge clk);
        check_en = 1'b0;
        if (errors == err_before) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int   e0;
        int   n;
        int   after;
        logic seen_left;
        logic seen_top;
        seed      = 11083;
        errors    = 0;
        checks    = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        check_en  = 1'b0;
        exp_rgb   = '0;
        exp_coll  = 1'b0;
        reset     = 1'b1;
        video_on  = 1'b0;
        x         = '0;
        y         = '0;
        board_x   = 10'd100;
        board_y   = 10'd460;
        place_bricks(20, 20, 100);
        apply_reset();

        // blanking gives black everywhere
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            probe(1'b0, breakout_pkg::coord_t'($random(seed)), breakout_pkg::coord_t'($random(seed)));
        end
        finish_test("reset and blanking", e0);

        // even probes anywhere on screen, odd probes around the ball
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            if (i % 2 == 0) begin
                probe(1'b1, breakout_pkg::coord_t'($unsigned($random(seed)) % 640),
                      breakout_pkg::coord_t'($unsigned($random(seed)) % 480));
            end else begin
                probe(1'b1, m_x - 10'd8 + breakout_pkg::coord_t'($unsigned($random(seed)) % 24),
                      m_y - 10'd8 + breakout_pkg::coord_t'($unsigned($random(seed)) % 24));
            end
        end
        finish_test("random pixels", e0);

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            frame_tick();
            check_ball();
        end
        finish_test("ball steps", e0);

        // board under the ball at the first frame turns it up and left
        apply_reset();
        board_x = 10'd290;
        board_y = 10'd399;
        place_bricks(400, 100, 35);
        e0        = errors;
        n         = 0;
        after     = 0;
        seen_left = 1'b0;
        seen_top  = 1'b0;
        while (after < 4 && !timed_out) begin
            if (n == 400) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: ball did not reach row 0 within 400 frames");
            end else begin
                frame_tick();
                check_ball();
                n++;
                if (m_x == '0) seen_left = 1'b1;
                if (m_y == '0) seen_top = 1'b1;
                if (seen_top) after++;
            end
        end
        if (!seen_left && !timed_out) begin
            errors++;
            $display("ball reached row 0 without passing column 0 first");
        end
        finish_test("wall bounces", e0);

        // board contact first, then a brick on the path up and left
        apply_reset();
        board_x = 10'd290;
        board_y = 10'd399;
        place_bricks(20, 100, 40);
        brick_x[0] = 10'd248;
        brick_y[0] = 10'd300;
        e0    = errors;
        n     = 0;
        after = 0;
        while (after < 3 && !timed_out) begin
            if (n == 100) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: ball did not reach the brick within 100 frames");
            end else begin
                frame_tick();
                check_ball();
                n++;
                if (m_coll) after++;
            end
        end
        finish_test("board and brick", e0);

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 passed, failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== logic/breakout_pixel_top.sv ====
`timescale 1ns/1ps

module breakout_pixel_top #(
    parameter int BOARD_WIDTH  = 64,
    parameter int BOARD_HEIGHT = 8,
    parameter int BRICK_WIDTH  = 30,
    parameter int BRICK_HEIGHT = 30,
    parameter int NUM_BRICKS   = 6,
    parameter int BALL_SIZE    = 8,
    parameter int BALL_SPEED   = 2,
    parameter int BALL_START_X = 316,
    parameter int BALL_START_Y = 392
) (
    input  logic                                   clk,
    input  logic                                   reset,
    // from the VGA sync generator
    input  logic                                   video_on,
    input  breakout_pkg::coord_t                   x,
    input  breakout_pkg::coord_t                   y,
    // top-left corner of the board
    input  breakout_pkg::coord_t                   board_x,
    input  breakout_pkg::coord_t                   board_y,
    // top-left corners of the bricks
    input  breakout_pkg::coord_t [NUM_BRICKS-1:0]  brick_x,
    input  breakout_pkg::coord_t [NUM_BRICKS-1:0]  brick_y,
    output breakout_pkg::rgb_t                     rgb,
    output logic                                   collision
);

    // ball state
    logic                 refresh_tick;
    breakout_pkg::coord_t ball_x;
    breakout_pkg::coord_t ball_y;
    breakout_pkg::vel_t   vel_x;
    breakout_pkg::vel_t   vel_y;
    logic                 ball_on;

    // brick results
    logic                 brick_on;
    logic                 ball_hits_brick;

    // velocity for the next frame
    breakout_pkg::vel_t   vel_x_next;
    breakout_pkg::vel_t   vel_y_next;

    ball_motion #(
        .BALL_SIZE    (BALL_SIZE),
        .BALL_SPEED   (BALL_SPEED),
        .BALL_START_X (BALL_START_X),
        .BALL_START_Y (BALL_START_Y)
    ) ball_motion_i (
        .clk          (clk),
        .reset        (reset),
        .x            (x),
        .y            (y),
        .vel_x_next   (vel_x_next),
        .vel_y_next   (vel_y_next),
        .refresh_tick (refresh_tick),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .vel_x        (vel_x),
        .vel_y        (vel_y),
        .ball_on      (ball_on)
    );

    brick_field #(
        .NUM_BRICKS   (NUM_BRICKS),
        .BRICK_WIDTH  (BRICK_WIDTH),
        .BRICK_HEIGHT (BRICK_HEIGHT),
        .BALL_SIZE    (BALL_SIZE)
    ) brick_field_i (
        .x               (x),
        .y               (y),
        .ball_x          (ball_x),
        .ball_y          (ball_y),
        .brick_x         (brick_x),
        .brick_y         (brick_y),
        .brick_on        (brick_on),
        .ball_hits_brick (ball_hits_brick)
    );

    bounce_control #(
        .BOARD_WIDTH  (BOARD_WIDTH),
        .BOARD_HEIGHT (BOARD_HEIGHT),
        .BALL_SIZE    (BALL_SIZE),
        .BALL_SPEED   (BALL_SPEED)
    ) bounce_control_i (
        .clk             (clk),
        .reset           (reset),
        .refresh_tick    (refresh_tick),
        .ball_x          (ball_x),
        .ball_y          (ball_y),
        .board_x         (board_x),
        .board_y         (board_y),
        .vel_x           (vel_x),
        .vel_y           (vel_y),
        .ball_hits_brick (ball_hits_brick),
        .vel_x_next      (vel_x_next),
        .vel_y_next      (vel_y_next),
        .collision       (collision)
    );

    pixel_color #(
        .BOARD_WIDTH  (BOARD_WIDTH),
        .BOARD_HEIGHT (BOARD_HEIGHT)
    ) pixel_color_i (
        .video_on (video_on),
        .x        (x),
        .y        (y),
        .board_x  (board_x),
        .board_y  (board_y),
        .ball_on  (ball_on),
        .brick_on (brick_on),
        .rgb      (rgb)
    );

endmodule

// ==== logic/pixel_color.sv ====
`timescale 1ns/1ps

module pixel_color #(
    parameter int BOARD_WIDTH  = 64,
    parameter int BOARD_HEIGHT = 8
) (
    input  logic                 video_on,
    input  breakout_pkg::coord_t x,
    input  breakout_pkg::coord_t y,
    input  breakout_pkg::coord_t board_x,
    input  breakout_pkg::coord_t board_y,
    input  logic                 ball_on,
    input  logic                 brick_on,
    output breakout_pkg::rgb_t   rgb
);

    // board right column and bottom row
    breakout_pkg::coord_t board_x_r;
    breakout_pkg::coord_t board_y_b;

    logic board_on;

    assign board_x_r = board_x + breakout_pkg::coord_t'(BOARD_WIDTH - 1);
    assign board_y_b = board_y + breakout_pkg::coord_t'(BOARD_HEIGHT - 1);

    // pixel on the board
    assign board_on = (board_x <= x) && (x <= board_x_r) &&
                      (board_y <= y) && (y <= board_y_b);

    // board over ball over brick over background
    always_comb begin
        if (!video_on) begin
            // blanking, drive black
            rgb = breakout_pkg::BLACK;
        end else if (board_on) begin
            rgb = breakout_pkg::BOARD_RGB;
        end else if (ball_on) begin
            rgb = breakout_pkg::BALL_RGB;
        end else if (brick_on) begin
            rgb = breakout_pkg::BRICK_RGB;
        end else begin
            rgb = breakout_pkg::BG_RGB;
        end
    end

endmodule

// ==== logic/bounce_control.sv ====
`timescale 1ns/1ps

module bounce_control #(
    parameter int BOARD_WIDTH  = 64,
    parameter int BOARD_HEIGHT = 8,
    parameter int BALL_SIZE    = 8,
    parameter int BALL_SPEED   = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 refresh_tick,
    input  breakout_pkg::coord_t ball_x,
    input  breakout_pkg::coord_t ball_y,
    input  breakout_pkg::coord_t board_x,
    input  breakout_pkg::coord_t board_y,
    input  breakout_pkg::vel_t   vel_x,
    input  breakout_pkg::vel_t   vel_y,
    input  logic                 ball_hits_brick,
    output breakout_pkg::vel_t   vel_x_next,
    output breakout_pkg::vel_t   vel_y_next,
    output logic                 collision
);

    localparam breakout_pkg::vel_t SPD_POS = breakout_pkg::vel_t'(BALL_SPEED);
    localparam breakout_pkg::vel_t SPD_NEG = breakout_pkg::vel_t'(-BALL_SPEED);

    // ball extent
    breakout_pkg::coord_t ball_x_r;
    breakout_pkg::coord_t ball_y_b;

    // last board column and the row just below the board
    breakout_pkg::coord_t board_x_lim;
    breakout_pkg::coord_t board_y_lim;

    logic board_hit;

    assign ball_x_r    = ball_x + breakout_pkg::coord_t'(BALL_SIZE - 1);
    assign ball_y_b    = ball_y + breakout_pkg::coord_t'(BALL_SIZE - 1);
    assign board_x_lim = board_x + breakout_pkg::coord_t'(BOARD_WIDTH - 1);
    assign board_y_lim = board_y + breakout_pkg::coord_t'(BOARD_HEIGHT);

    // ball bottom within the board rows and columns overlapping
    assign board_hit = (ball_y_b >= board_y) && (ball_y_b <= board_y_lim) &&
                       (ball_x_r >= board_x) && (ball_x <= board_x_lim);

    always_comb begin
        vel_x_next = vel_x;
        vel_y_next = vel_y;

        // vertical checks with the top wall first
        if (ball_y == '0) begin
            vel_y_next = SPD_POS;
        end else if (ball_y > breakout_pkg::Y_MAX) begin
            // wrapped above row 0 or fell below the screen
            vel_y_next = SPD_NEG;
        end else if (board_hit) begin
            vel_y_next = SPD_NEG;
            vel_x_next = -vel_x;
        end else if (ball_hits_brick) begin
            vel_y_next = SPD_NEG;
            vel_x_next = -vel_x;
        end

        // side walls win over any x bounce above
        if (ball_x == '0) begin
            vel_x_next = SPD_POS;
        end else if (ball_x_r > breakout_pkg::X_MAX) begin
            vel_x_next = SPD_NEG;
        end
    end

    // sticky flag set on the frame tick of the first brick contact
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            collision <= 1'b0;
        end else if (refresh_tick && ball_hits_brick) begin
            collision <= 1'b1;
        end
    end

    // velocity registers in ball_motion only ever hold a full step
    velocity_is_full_step: assert property (
        @(posedge clk) disable iff (reset)
        ((vel_x == SPD_POS) || (vel_x == SPD_NEG)) &&
        ((vel_y == SPD_POS) || (vel_y == SPD_NEG))
    );

endmodule

// ==== logic/brick_field.sv ====
`timescale 1ns/1ps

module brick_field #(
    parameter int NUM_BRICKS   = 6,
    parameter int BRICK_WIDTH  = 30,
    parameter int BRICK_HEIGHT = 30,
    parameter int BALL_SIZE    = 8
) (
    input  breakout_pkg::coord_t                   x,
    input  breakout_pkg::coord_t                   y,
    input  breakout_pkg::coord_t                   ball_x,
    input  breakout_pkg::coord_t                   ball_y,
    input  breakout_pkg::coord_t [NUM_BRICKS-1:0]  brick_x,
    input  breakout_pkg::coord_t [NUM_BRICKS-1:0]  brick_y,
    output logic                                   brick_on,
    output logic                                   ball_hits_brick
);

    // ball right column and bottom row
    breakout_pkg::coord_t ball_x_r;
    breakout_pkg::coord_t ball_y_b;

    // one bit per brick
    logic [NUM_BRICKS-1:0] pixel_in;
    logic [NUM_BRICKS-1:0] overlap;

    assign ball_x_r = ball_x + breakout_pkg::coord_t'(BALL_SIZE - 1);
    assign ball_y_b = ball_y + breakout_pkg::coord_t'(BALL_SIZE - 1);

    for (genvar i = 0; i < NUM_BRICKS; i++) begin : g_brick
        // brick right and bottom edges
        breakout_pkg::coord_t brick_x_r;
        breakout_pkg::coord_t brick_y_b;

        assign brick_x_r = brick_x[i] + breakout_pkg::coord_t'(BRICK_WIDTH - 1);
        assign brick_y_b = brick_y[i] + breakout_pkg::coord_t'(BRICK_HEIGHT - 1);

        // pixel falls inside this brick
        assign pixel_in[i] = (brick_x[i] <= x) && (x <= brick_x_r) &&
                             (brick_y[i] <= y) && (y <= brick_y_b);

        // ball bottom in the brick rows with overlapping columns
        assign overlap[i] = (ball_y_b >= brick_y[i]) && (ball_y_b <= brick_y_b) &&
                            (ball_x_r >= brick_x[i]) && (ball_x <= brick_x_r);
    end

    assign brick_on        = |pixel_in;
    assign ball_hits_brick = |overlap;

endmodule

// ==== logic/ball_motion.sv ====
`timescale 1ns/1ps

module ball_motion #(
    parameter int BALL_SIZE    = 8,
    parameter int BALL_SPEED   = 2,
    parameter int BALL_START_X = 316,
    parameter int BALL_START_Y = 392
) (
    input  logic                 clk,
    input  logic                 reset,
    input  breakout_pkg::coord_t x,
    input  breakout_pkg::coord_t y,
    input  breakout_pkg::vel_t   vel_x_next,
    input  breakout_pkg::vel_t   vel_y_next,
    output logic                 refresh_tick,
    output breakout_pkg::coord_t ball_x,
    output breakout_pkg::coord_t ball_y,
    output breakout_pkg::vel_t   vel_x,
    output breakout_pkg::vel_t   vel_y,
    output logic                 ball_on
);

    // step sizes in both directions
    localparam breakout_pkg::vel_t SPD_POS = breakout_pkg::vel_t'(BALL_SPEED);
    localparam breakout_pkg::vel_t SPD_NEG = breakout_pkg::vel_t'(-BALL_SPEED);

    // right column and bottom row of the ball
    breakout_pkg::coord_t ball_x_r;
    breakout_pkg::coord_t ball_y_b;

    // one pulse per frame, first pixel of the refresh line in vertical blanking
    assign refresh_tick = (y == breakout_pkg::REFRESH_LINE) && (x == '0);

    // position moves by the current step, velocity takes the bounce result
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ball_x <= breakout_pkg::coord_t'(BALL_START_X);
            ball_y <= breakout_pkg::coord_t'(BALL_START_Y);
            // start moving right and up
            vel_x  <= SPD_POS;
            vel_y  <= SPD_NEG;
        end else if (refresh_tick) begin
            // unsigned add wraps, same as adding the signed step
            ball_x <= ball_x + breakout_pkg::coord_t'(vel_x);
            ball_y <= ball_y + breakout_pkg::coord_t'(vel_y);
            vel_x  <= vel_x_next;
            vel_y  <= vel_y_next;
        end
    end

    // ball extent
    assign ball_x_r = ball_x + breakout_pkg::coord_t'(BALL_SIZE - 1);
    assign ball_y_b = ball_y + breakout_pkg::coord_t'(BALL_SIZE - 1);

    // current pixel inside the ball square
    assign ball_on = (ball_x <= x) && (x <= ball_x_r) &&
                     (ball_y <= y) && (y <= ball_y_b);

    // the ball only moves once per frame
    position_holds_between_ticks: assert property (
        @(posedge clk) disable iff (reset)
        !refresh_tick |=> $stable(ball_x) && $stable(ball_y)
    );

endmodule

// ==== logic/breakout_pkg.sv ====
package breakout_pkg;

    // width of a screen coordinate
    localparam int COORD_W = 10;

    // unsigned pixel coordinate
    typedef logic [COORD_W-1:0] coord_t;
    // signed per-frame ball step in two's complement
    typedef logic signed [COORD_W-1:0] vel_t;
    // 4 bits per channel
    typedef logic [11:0] rgb_t;

    // last visible column and row
    localparam coord_t X_MAX = 10'd639;
    localparam coord_t Y_MAX = 10'd479;

    // row in vertical blanking whose first column marks the frame tick
    localparam coord_t REFRESH_LINE = 10'd481;

    // colours
    localparam rgb_t BLACK     = 12'h000;
    localparam rgb_t BG_RGB    = 12'h0F0;
    // white board
    localparam rgb_t BOARD_RGB = 12'hFFF;
    localparam rgb_t BRICK_RGB = 12'hF00;
    // red and green make a yellow ball
    localparam rgb_t BALL_RGB  = 12'hFF0;

endpackage
